//--- design/sa_cfg_pkg.sv
package sa_cfg_pkg;

  //////////////////////////////////////////////////
  // array geometry
  //////////////////////////////////////////////////

  // rows carry weights, columns carry pixel pairs
  localparam int sa_rows = 4;
  localparam int sa_cols = 4;

  // raw input fields
  localparam int pix_w = 8;
  localparam int wgt_w = 8;

  //////////////////////////////////////////////////
  // operand and lane widths
  //////////////////////////////////////////////////

  // wide multiplier ports, 25 x 25 signed
  localparam int opa_w  = 25;
  localparam int opb_w  = 25;
  localparam int prod_w = opa_w + opb_w;

  // lane spacing inside the wide operands
  localparam int fld88_w = 16;
  localparam int fld18_w = 9;

  // accumulator word and its lanes
  localparam int acc_w    = 64;
  localparam int lane88_w = 24;
  localparam int lane18_w = 16;

  // drain sequencer, one shift per array row
  localparam int drain_w = $clog2(sa_rows + 1);
  localparam logic [drain_w-1:0] drain_len = drain_w'(sa_rows);

  //////////////////////////////////////////////////
  // result buffer and credits
  //////////////////////////////////////////////////

  localparam int rowbuf_depth = 4;
  localparam int ptr_w = $clog2(rowbuf_depth);
  localparam int cnt_w = $clog2(rowbuf_depth + 1);
  // one credit per buffer slot
  localparam logic [cnt_w-1:0] credit_init = cnt_w'(rowbuf_depth);
  localparam int row_out_w = sa_cols * acc_w;

endpackage

//--- design/sa_data_pkg.sv
package sa_data_pkg;

  // mode 0: 8-bit pixels x signed 8-bit weight
  // mode 1: 8-bit pixels x binary weights
  typedef enum logic {
    mode_88 = 1'b0,
    mode_18 = 1'b1
  } sa_mode_t;

  //////////////////////////////////////////////////
  // accumulator word, two views of the same 64 bits
  //////////////////////////////////////////////////

  // mode 0 view, two wide lanes and an unused top
  typedef struct packed {
    logic [sa_cfg_pkg::acc_w-2*sa_cfg_pkg::lane88_w-1:0] pad;
    logic signed [sa_cfg_pkg::lane88_w-1:0]              p1_w;
    logic signed [sa_cfg_pkg::lane88_w-1:0]              p0_w;
  } acc88_t;

  // mode 1 view, four narrow lanes
  // upper pair uses weight bit 1, lower pair weight bit 0
  typedef struct packed {
    logic signed [sa_cfg_pkg::lane18_w-1:0] p1_w1;
    logic signed [sa_cfg_pkg::lane18_w-1:0] p0_w1;
    logic signed [sa_cfg_pkg::lane18_w-1:0] p1_w0;
    logic signed [sa_cfg_pkg::lane18_w-1:0] p0_w0;
  } acc18_t;

  typedef union packed {
    acc88_t m88;
    acc18_t m18;
  } acc_word_t;

endpackage

//--- design/operand_packer.sv
`timescale 1ns/1ps

module operand_packer (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  sa_data_pkg::sa_mode_t                                 mode,
  input  logic [sa_cfg_pkg::sa_cols*2*sa_cfg_pkg::pix_w-1:0]    pix_in,
  input  logic [sa_cfg_pkg::sa_rows*sa_cfg_pkg::wgt_w-1:0]      wgt_in,
  input  logic                                                  in_valid,
  input  logic                                                  in_last,
  output logic [sa_cfg_pkg::sa_cols-1:0][sa_cfg_pkg::opa_w-1:0] pa,
  output logic [sa_cfg_pkg::sa_rows-1:0][sa_cfg_pkg::opb_w-1:0] pb,
  output logic [sa_cfg_pkg::sa_rows-1:0]                        a_valid,
  output logic [sa_cfg_pkg::sa_rows-1:0]                        a_first,
  output logic [sa_cfg_pkg::sa_rows-1:0]                        a_last
);

  localparam int R  = sa_cfg_pkg::sa_rows;
  localparam int C  = sa_cfg_pkg::sa_cols;
  localparam int PW = sa_cfg_pkg::pix_w;
  localparam int WW = sa_cfg_pkg::wgt_w;
  localparam int AW = sa_cfg_pkg::opa_w;
  localparam int BW = sa_cfg_pkg::opb_w;

  // mode 1 weight lanes, plus or minus one at bit 0 and bit 18
  localparam logic [BW-1:0] plus_lo  = BW'(1);
  localparam logic [BW-1:0] minus_lo = '1;
  localparam logic [BW-1:0] plus_hi  = plus_lo << (2*sa_cfg_pkg::fld18_w);
  localparam logic [BW-1:0] minus_hi = minus_lo << (2*sa_cfg_pkg::fld18_w);

  logic [AW-1:0] pa_pack [C];
  logic [BW-1:0] pb_pack [R];
  logic          in_tile;
  logic          first;

  //////////////////////////////////////////////////
  // operand packing
  //////////////////////////////////////////////////

  // pixel 0 sits in the low byte of each column pair
  always_comb begin
    for (int c = 0; c < C; c++) begin
      if (mode == sa_data_pkg::mode_88) begin
        pa_pack[c] = (AW'(pix_in[c*2*PW+PW +: PW]) << sa_cfg_pkg::fld88_w)
                   | AW'(pix_in[c*2*PW +: PW]);
      end else begin
        pa_pack[c] = (AW'(pix_in[c*2*PW+PW +: PW]) << sa_cfg_pkg::fld18_w)
                   | AW'(pix_in[c*2*PW +: PW]);
      end
    end
  end

  always_comb begin
    for (int r = 0; r < R; r++) begin
      if (mode == sa_data_pkg::mode_88) begin
        pb_pack[r] = {{(BW-WW){wgt_in[r*WW+WW-1]}}, wgt_in[r*WW +: WW]};
      end else begin
        // bit set means minus one
        pb_pack[r] = (wgt_in[r*WW+1] ? minus_hi : plus_hi)
                   + (wgt_in[r*WW] ? minus_lo : plus_lo);
      end
    end
  end

  // high between the first and last step of a tile
  always_ff @(posedge clk) begin
    if (reset) begin
      in_tile <= 1'b0;
    end else if (in_valid) begin
      in_tile <= !in_last;
    end
  end

  assign first = in_valid && !in_tile;

  //////////////////////////////////////////////////
  // skew
  //////////////////////////////////////////////////

  // weights and flags, input register plus r stages
  for (genvar r = 0; r < R; r++) begin : g_row
    logic [BW-1:0] b_d [r+1];
    logic [r:0]    v_d;
    logic [r:0]    f_d;
    logic [r:0]    l_d;

    always_ff @(posedge clk) begin
      b_d[0] <= pb_pack[r];
      for (int i = 1; i <= r; i++) begin
        b_d[i] <= b_d[i-1];
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        v_d <= '0;
        f_d <= '0;
        l_d <= '0;
      end else begin
        v_d[0] <= in_valid;
        f_d[0] <= first;
        l_d[0] <= in_valid && in_last;
        for (int i = 1; i <= r; i++) begin
          v_d[i] <= v_d[i-1];
          f_d[i] <= f_d[i-1];
          l_d[i] <= l_d[i-1];
        end
      end
    end

    assign pb[r]      = b_d[r];
    assign a_valid[r] = v_d[r];
    assign a_first[r] = f_d[r];
    assign a_last[r]  = l_d[r];
  end

  // pixel pairs, input register plus c stages
  for (genvar c = 0; c < C; c++) begin : g_col
    logic [AW-1:0] a_d [c+1];

    always_ff @(posedge clk) begin
      a_d[0] <= pa_pack[c];
      for (int i = 1; i <= c; i++) begin
        a_d[i] <= a_d[i-1];
      end
    end

    assign pa[c] = a_d[c];
  end

endmodule

//--- design/mac_cell.sv
`timescale 1ns/1ps

module mac_cell (
  input  logic                             clk,
  input  logic                             reset,
  input  sa_data_pkg::sa_mode_t            mode,
  input  logic [sa_cfg_pkg::opa_w-1:0]     a_in,
  input  logic [sa_cfg_pkg::opb_w-1:0]     b_in,
  input  logic                             valid_in,
  input  logic                             first_in,
  input  logic                             last_in,
  output logic [sa_cfg_pkg::opa_w-1:0]     a_out,
  output logic [sa_cfg_pkg::opb_w-1:0]     b_out,
  output logic                             valid_out,
  output logic                             first_out,
  output logic                             last_out,
  input  logic                             shift,
  input  sa_data_pkg::acc_word_t           shift_in,
  output sa_data_pkg::acc_word_t           acc
);

  logic signed [sa_cfg_pkg::prod_w-1:0]   prod;
  // mode 0 lane products
  logic signed [sa_cfg_pkg::fld88_w-1:0]  t88_lo;
  logic signed [sa_cfg_pkg::fld88_w-1:0]  t88_hi;
  // mode 1 lane products, lowest lane first
  logic signed [sa_cfg_pkg::fld18_w-1:0]  t18 [4];
  sa_data_pkg::acc_word_t                 acc_base;
  sa_data_pkg::acc_word_t                 acc_next;

  // one wide multiply covers every lane
  assign prod = $signed(a_in) * $signed(b_in);

  //////////////////////////////////////////////////
  // lane extraction
  //////////////////////////////////////////////////

  // a negative lower lane borrows one from the lane above,
  // its raw sign bit gives that borrow back
  assign t88_lo = prod[sa_cfg_pkg::fld88_w-1:0];
  assign t88_hi = prod[2*sa_cfg_pkg::fld88_w-1:sa_cfg_pkg::fld88_w]
                + {{(sa_cfg_pkg::fld88_w-1){1'b0}}, prod[sa_cfg_pkg::fld88_w-1]};

  for (genvar k = 0; k < 4; k++) begin : g_lane18
    if (k == 0) begin : g_base
      assign t18[k] = prod[sa_cfg_pkg::fld18_w-1:0];
    end else begin : g_borrow
      assign t18[k] = prod[k*sa_cfg_pkg::fld18_w +: sa_cfg_pkg::fld18_w]
                    + {{(sa_cfg_pkg::fld18_w-1){1'b0}}, prod[k*sa_cfg_pkg::fld18_w-1]};
    end
  end

  //////////////////////////////////////////////////
  // accumulate
  //////////////////////////////////////////////////

  // first step of a tile starts from zero
  always_comb begin
    acc_base = first_in ? '0 : acc;
    acc_next = acc_base;
    if (mode == sa_data_pkg::mode_88) begin
      acc_next.m88.pad  = '0;
      acc_next.m88.p1_w = acc_base.m88.p1_w + t88_hi;
      acc_next.m88.p0_w = acc_base.m88.p0_w + t88_lo;
    end else begin
      acc_next.m18.p1_w1 = acc_base.m18.p1_w1 + t18[3];
      acc_next.m18.p0_w1 = acc_base.m18.p0_w1 + t18[2];
      acc_next.m18.p1_w0 = acc_base.m18.p1_w0 + t18[1];
      acc_next.m18.p0_w0 = acc_base.m18.p0_w0 + t18[0];
    end
  end

  // readout shift wins, results move one row down
  always_ff @(posedge clk) begin
    if (shift) begin
      acc <= shift_in;
    end else if (valid_in) begin
      acc <= acc_next;
    end
  end

  // operands pass on to the right and below
  always_ff @(posedge clk) begin
    a_out <= a_in;
    b_out <= b_in;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      first_out <= 1'b0;
      last_out  <= 1'b0;
    end else begin
      valid_out <= valid_in;
      first_out <= first_in;
      last_out  <= last_in;
    end
  end

endmodule

//--- design/mac_array.sv
`timescale 1ns/1ps

module mac_array (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  sa_data_pkg::sa_mode_t                                 mode,
  input  logic [sa_cfg_pkg::sa_cols-1:0][sa_cfg_pkg::opa_w-1:0] pa,
  input  logic [sa_cfg_pkg::sa_rows-1:0][sa_cfg_pkg::opb_w-1:0] pb,
  input  logic [sa_cfg_pkg::sa_rows-1:0]                        a_valid,
  input  logic [sa_cfg_pkg::sa_rows-1:0]                        a_first,
  input  logic [sa_cfg_pkg::sa_rows-1:0]                        a_last,
  output sa_data_pkg::acc_word_t [sa_cfg_pkg::sa_cols-1:0]      drain_word,
  output logic [sa_cfg_pkg::sa_cols-1:0]                        drain_valid,
  output logic                                                  idle
);

  localparam int R = sa_cfg_pkg::sa_rows;
  localparam int C = sa_cfg_pkg::sa_cols;

  // operands moving down (pixels) and right (weights)
  logic [sa_cfg_pkg::opa_w-1:0] a_dn [R][C];
  logic [sa_cfg_pkg::opb_w-1:0] b_rt [R][C];
  // tile flags travel with the weights
  logic                         v_rt [R][C];
  logic                         f_rt [R][C];
  logic                         l_rt [R][C];
  sa_data_pkg::acc_word_t       acc_q [R][C];

  logic [sa_cfg_pkg::drain_w-1:0] drain_cnt;
  logic [C-1:1]                   shift_q;
  logic [C-1:0]                   shift;
  logic                           busy;

  //////////////////////////////////////////////////
  // cell grid
  //////////////////////////////////////////////////

  for (genvar r = 0; r < R; r++) begin : g_row
    for (genvar c = 0; c < C; c++) begin : g_col
      mac_cell u_cell (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .a_in      ((r == 0) ? pa[c] : a_dn[(r == 0) ? 0 : r-1][c]),
        .b_in      ((c == 0) ? pb[r] : b_rt[r][(c == 0) ? 0 : c-1]),
        .valid_in  ((c == 0) ? a_valid[r] : v_rt[r][(c == 0) ? 0 : c-1]),
        .first_in  ((c == 0) ? a_first[r] : f_rt[r][(c == 0) ? 0 : c-1]),
        .last_in   ((c == 0) ? a_last[r] : l_rt[r][(c == 0) ? 0 : c-1]),
        .a_out     (a_dn[r][c]),
        .b_out     (b_rt[r][c]),
        .valid_out (v_rt[r][c]),
        .first_out (f_rt[r][c]),
        .last_out  (l_rt[r][c]),
        .shift     (shift[c]),
        // top row pulls in zeros while draining
        .shift_in  ((r == 0) ? '0 : acc_q[(r == 0) ? 0 : r-1][c]),
        .acc       (acc_q[r][c])
      );
    end
  end

  //////////////////////////////////////////////////
  // drain sequencer
  //////////////////////////////////////////////////

  // last flag out of the corner cell means every sum is final
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_cnt <= '0;
    end else if (l_rt[R-1][C-1]) begin
      drain_cnt <= sa_cfg_pkg::drain_len;
    end else if (drain_cnt != '0) begin
      drain_cnt <= drain_cnt - 1'b1;
    end
  end

  // later columns shift one cycle behind their left neighbor
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q <= '0;
    end else begin
      shift_q <= shift[C-2:0];
    end
  end

  assign shift = {shift_q, drain_cnt != '0};

  // bottom row leaves first, row 3 then row 2 and so on
  for (genvar c = 0; c < C; c++) begin : g_out
    assign drain_word[c] = acc_q[R-1][c];
  end
  assign drain_valid = shift;

  // any flag in flight or any column still draining
  always_comb begin
    busy = (|a_valid) | (|shift);
    for (int r = 0; r < R; r++) begin
      for (int c = 0; c < C; c++) begin
        busy = busy | v_rt[r][c];
      end
    end
  end

  assign idle = ~busy;

endmodule

//--- design/sum_deskew.sv
`timescale 1ns/1ps

module sum_deskew (
  input  logic                                             clk,
  input  logic                                             reset,
  input  sa_data_pkg::acc_word_t [sa_cfg_pkg::sa_cols-1:0] drain_word,
  input  logic [sa_cfg_pkg::sa_cols-1:0]                   drain_valid,
  output sa_data_pkg::acc_word_t [sa_cfg_pkg::sa_cols-1:0] row_word,
  output logic                                             row_valid
);

  localparam int C = sa_cfg_pkg::sa_cols;

  // valid of column 0, delayed as long as its words
  logic [C-2:0] v0_d;

  // column c emits c cycles after column 0,
  // so it waits C-1-c cycles to line up
  for (genvar c = 0; c < C; c++) begin : g_col
    if (c == C-1) begin : g_direct
      assign row_word[c] = drain_word[c];
    end else begin : g_delay
      sa_data_pkg::acc_word_t w_d [C-1-c];

      always_ff @(posedge clk) begin
        w_d[0] <= drain_word[c];
        for (int i = 1; i < C-1-c; i++) begin
          w_d[i] <= w_d[i-1];
        end
      end

      assign row_word[c] = w_d[C-2-c];
    end
  end

  // later columns drain in step with column 0
  always_ff @(posedge clk) begin
    if (reset) begin
      v0_d <= '0;
    end else begin
      v0_d <= {v0_d[C-3:0], drain_valid[0]};
    end
  end

  assign row_valid = v0_d[C-2];

endmodule

//--- design/result_unpacker.sv
`timescale 1ns/1ps

module result_unpacker (
  input  logic                                             clk,
  input  logic                                             reset,
  input  sa_data_pkg::sa_mode_t                            mode,
  input  sa_data_pkg::acc_word_t [sa_cfg_pkg::sa_cols-1:0] row_word,
  input  logic                                             row_valid,
  input  logic                                             idle,
  input  logic                                             credit_return,
  output logic [sa_cfg_pkg::row_out_w-1:0]                 out_row,
  output logic                                             out_valid,
  output logic                                             tile_ready
);

  localparam int AW = sa_cfg_pkg::acc_w;
  // sign bits added to each mode 0 lane
  localparam int EXT = sa_cfg_pkg::acc_w/2 - sa_cfg_pkg::lane88_w;

  logic [sa_cfg_pkg::row_out_w-1:0] unpacked;
  logic [sa_cfg_pkg::row_out_w-1:0] mem [sa_cfg_pkg::rowbuf_depth];
  logic [sa_cfg_pkg::ptr_w-1:0]     wr_ptr;
  logic [sa_cfg_pkg::ptr_w-1:0]     rd_ptr;
  logic [sa_cfg_pkg::cnt_w-1:0]     count;
  logic [sa_cfg_pkg::cnt_w-1:0]     credits;

  //////////////////////////////////////////////////
  // lane unpack
  //////////////////////////////////////////////////

  // mode 0 widens two 24-bit lanes to 32 bits,
  // mode 1 lanes are already 16 bits each
  always_comb begin
    for (int c = 0; c < sa_cfg_pkg::sa_cols; c++) begin
      if (mode == sa_data_pkg::mode_88) begin
        unpacked[c*AW +: AW] = {
          {EXT{row_word[c].m88.p1_w[sa_cfg_pkg::lane88_w-1]}}, row_word[c].m88.p1_w,
          {EXT{row_word[c].m88.p0_w[sa_cfg_pkg::lane88_w-1]}}, row_word[c].m88.p0_w
        };
      end else begin
        unpacked[c*AW +: AW] = row_word[c];
      end
    end
  end

  //////////////////////////////////////////////////
  // row buffer and credits
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (row_valid) begin
      mem[wr_ptr] <= unpacked;
    end
  end

  // a row goes out only with a credit in hand
  assign out_valid = (count != '0) && (credits != '0);
  assign out_row   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= sa_cfg_pkg::credit_init;
    end else begin
      if (row_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (row_valid && !out_valid) begin
        count <= count + 1'b1;
      end else if (!row_valid && out_valid) begin
        count <= count - 1'b1;
      end
      if (credit_return && !out_valid) begin
        credits <= credits + 1'b1;
      end else if (!credit_return && out_valid) begin
        credits <= credits - 1'b1;
      end
    end
  end

  // next tile only into an empty buffer behind an idle array
  assign tile_ready = idle && (count == '0);

endmodule

//--- design/packed_sa_top.sv
`timescale 1ns/1ps

module packed_sa_top (
  input  logic                                               clk,
  input  logic                                               reset,
  input  sa_data_pkg::sa_mode_t                              mode_init,
  input  logic [sa_cfg_pkg::sa_cols*2*sa_cfg_pkg::pix_w-1:0] pix_in,
  input  logic [sa_cfg_pkg::sa_rows*sa_cfg_pkg::wgt_w-1:0]   wgt_in,
  input  logic                                               in_valid,
  input  logic                                               in_last,
  input  logic                                               credit_return,
  output logic [sa_cfg_pkg::row_out_w-1:0]                   out_row,
  output logic                                               out_valid,
  output logic                                               tile_ready
);

  sa_data_pkg::sa_mode_t                                 mode;
  logic [sa_cfg_pkg::sa_cols-1:0][sa_cfg_pkg::opa_w-1:0] pa;
  logic [sa_cfg_pkg::sa_rows-1:0][sa_cfg_pkg::opb_w-1:0] pb;
  logic [sa_cfg_pkg::sa_rows-1:0]                        a_valid;
  logic [sa_cfg_pkg::sa_rows-1:0]                        a_first;
  logic [sa_cfg_pkg::sa_rows-1:0]                        a_last;
  sa_data_pkg::acc_word_t [sa_cfg_pkg::sa_cols-1:0]      drain_word;
  logic [sa_cfg_pkg::sa_cols-1:0]                        drain_valid;
  sa_data_pkg::acc_word_t [sa_cfg_pkg::sa_cols-1:0]      row_word;
  logic                                                  row_valid;
  logic                                                  idle;

  // mode is latched during reset and held afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      mode <= mode_init;
    end
  end

  operand_packer u_pack (
    .clk (clk), .reset (reset), .mode (mode),
    .pix_in (pix_in), .wgt_in (wgt_in), .in_valid (in_valid), .in_last (in_last),
    .pa (pa), .pb (pb), .a_valid (a_valid), .a_first (a_first), .a_last (a_last)
  );

  mac_array u_array (
    .clk (clk), .reset (reset), .mode (mode),
    .pa (pa), .pb (pb), .a_valid (a_valid), .a_first (a_first), .a_last (a_last),
    .drain_word (drain_word), .drain_valid (drain_valid), .idle (idle)
  );

  sum_deskew u_deskew (
    .clk (clk), .reset (reset),
    .drain_word (drain_word), .drain_valid (drain_valid),
    .row_word (row_word), .row_valid (row_valid)
  );

  result_unpacker u_unpack (
    .clk (clk), .reset (reset), .mode (mode),
    .row_word (row_word), .row_valid (row_valid), .idle (idle),
    .credit_return (credit_return),
    .out_row (out_row), .out_valid (out_valid), .tile_ready (tile_ready)
  );

endmodule

//--- test/tb_packed_sa_ref.svh
//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

// lane sums of one cell over the stored tile
// row r takes weight r, column c takes pixel pair c
function automatic sa_data_pkg::acc_word_t ref_word(
  input sa_data_pkg::sa_mode_t mode,
  input int                    k_len,
  input int                    r,
  input int                    c
);
  int                     s0;
  int                     s1;
  int                     s2;
  int                     s3;
  int                     p0;
  int                     p1;
  int                     w;
  sa_data_pkg::acc_word_t word;
  s0 = 0;
  s1 = 0;
  s2 = 0;
  s3 = 0;
  for (int k = 0; k < k_len; k++) begin
    // pixels are unsigned bytes, low byte is pixel 0
    p0 = int'(tile_pix[k][c][7:0]);
    p1 = int'(tile_pix[k][c][15:8]);
    if (mode == sa_data_pkg::mode_88) begin
      w = int'($signed(tile_wgt[k][r]));
      s0 += p0 * w;
      s1 += p1 * w;
    end else begin
      // binary weight, bit set means minus one
      s0 += tile_wgt[k][r][0] ? -p0 : p0;
      s1 += tile_wgt[k][r][0] ? -p1 : p1;
      s2 += tile_wgt[k][r][1] ? -p0 : p0;
      s3 += tile_wgt[k][r][1] ? -p1 : p1;
    end
  end
  if (mode == sa_data_pkg::mode_88) begin
    // two 32-bit lanes after unpacking
    word = {s1, s0};
  end else begin
    word.m18.p1_w1 = s3[15:0];
    word.m18.p0_w1 = s2[15:0];
    word.m18.p1_w0 = s1[15:0];
    word.m18.p0_w0 = s0[15:0];
  end
  return word;
endfunction

// whole output row, column c at word c
function automatic logic [sa_cfg_pkg::row_out_w-1:0] ref_row(
  input sa_data_pkg::sa_mode_t mode,
  input int                    k_len,
  input int                    r
);
  logic [sa_cfg_pkg::row_out_w-1:0] row;
  for (int c = 0; c < sa_cfg_pkg::sa_cols; c++) begin
    row[c*sa_cfg_pkg::acc_w +: sa_cfg_pkg::acc_w] = ref_word(mode, k_len, r, c);
  end
  return row;
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_row(
  input logic [sa_cfg_pkg::row_out_w-1:0] got,
  input logic [sa_cfg_pkg::row_out_w-1:0] exp
);
  sa_data_pkg::acc_word_t g;
  sa_data_pkg::acc_word_t e;
  logic                   bad;
  bad = 1'b0;
  checks++;
  for (int c = 0; c < sa_cfg_pkg::sa_cols; c++) begin
    g = got[c*sa_cfg_pkg::acc_w +: sa_cfg_pkg::acc_w];
    e = exp[c*sa_cfg_pkg::acc_w +: sa_cfg_pkg::acc_w];
    if (g !== e) begin
      bad = 1'b1;
      if (cur_mode == sa_data_pkg::mode_18) begin
        $display("ERR at %0t: col %0d lanes got %0d %0d %0d %0d exp %0d %0d %0d %0d",
                 $time, c, g.m18.p1_w1, g.m18.p0_w1, g.m18.p1_w0, g.m18.p0_w0,
                 e.m18.p1_w1, e.m18.p0_w1, e.m18.p1_w0, e.m18.p0_w0);
      end else begin
        $display("ERR at %0t: col %0d lanes got %0d %0d exp %0d %0d", $time, c,
                 $signed(g[63:32]), $signed(g[31:0]), $signed(e[63:32]), $signed(e[31:0]));
      end
    end
  end
  if (bad) begin
    errors++;
  end
endtask

task automatic check_ready(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp) begin
    $display("ERR at %0t: %s is %b, expected %b", $time, what, got, exp);
    errors++;
  end
endtask

// rows handed out but not yet paid back by credit_return
task automatic check_credit(input int outstanding);
  checks++;
  if (outstanding >= sa_cfg_pkg::rowbuf_depth) begin
    $display("ERR at %0t: out_valid with %0d rows unpaid, no credit left",
             $time, outstanding);
    errors++;
  end
endtask

//--- test/tb_packed_sa.sv
`timescale 1ns/1ps

module tb_packed_sa;

  localparam int R          = sa_cfg_pkg::sa_rows;
  localparam int C          = sa_cfg_pkg::sa_cols;
  localparam int RW         = sa_cfg_pkg::row_out_w;
  localparam int kmax       = 64;
  localparam int wait_limit = 4000;

  logic                               clk;
  logic                               reset;
  sa_data_pkg::sa_mode_t              mode_init;
  logic [C*2*sa_cfg_pkg::pix_w-1:0]   pix_in;
  logic [R*sa_cfg_pkg::wgt_w-1:0]     wgt_in;
  logic                               in_valid;
  logic                               in_last;
  logic                               credit_return;
  logic [RW-1:0]                      out_row;
  logic                               out_valid;
  logic                               tile_ready;

  // operands of the tile last driven
  logic [2*sa_cfg_pkg::pix_w-1:0]     tile_pix [kmax][C];
  logic [sa_cfg_pkg::wgt_w-1:0]       tile_wgt [kmax][R];
  // expected rows, bottom array row first
  logic [RW-1:0]                      exp_q [$];

  sa_data_pkg::sa_mode_t              cur_mode;
  logic [31:0]                        stim_lfsr;
  logic [31:0]                        crd_lfsr;
  int                                 errors;
  int                                 checks;
  int                                 rows_total;
  int                                 returned_total;
  int                                 issued_total;
  int                                 hold_cnt;
  int                                 err_mark;
  int                                 row_mark;
  logic                               bp_on;
  logic                               timed_out;

  `include "tb_packed_sa_ref.svh"

  packed_sa_top uut (
    .clk           (clk),
    .reset         (reset),
    .mode_init     (mode_init),
    .pix_in        (pix_in),
    .wgt_in        (wgt_in),
    .in_valid      (in_valid),
    .in_last       (in_last),
    .credit_return (credit_return),
    .out_row       (out_row),
    .out_valid     (out_valid),
    .tile_ready    (tile_ready)
  );

  // 8 ns period
  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  // one step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val   = {val[30:0], state[0]};
      state = lfsr_step(state);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic apply_reset(input sa_data_pkg::sa_mode_t mode);
    @(negedge clk);
    reset     = 1'b1;
    mode_init = mode;
    cur_mode  = mode;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (!tile_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!tile_ready) begin
      $display("timeout: tile_ready never rose during %s", what);
      timed_out = 1'b1;
    end
  endtask

  // one tile of k_len steps, starts on the first negedge with tile_ready
  task automatic drive_tile(input int k_len);
    logic [31:0] v;
    if (timed_out) begin
      return;
    end
    wait_ready("tile start");
    if (timed_out) begin
      return;
    end
    for (int k = 0; k < k_len; k++) begin
      for (int c = 0; c < C; c++) begin
        draw_bits(stim_lfsr, 16, v);
        tile_pix[k][c]     = v[15:0];
        pix_in[c*16 +: 16] = v[15:0];
      end
      // full byte even in mode 1, upper bits must be ignored
      for (int r = 0; r < R; r++) begin
        draw_bits(stim_lfsr, 8, v);
        tile_wgt[k][r]    = v[7:0];
        wgt_in[r*8 +: 8]  = v[7:0];
      end
      in_valid = 1'b1;
      in_last  = (k == k_len - 1);
      @(negedge clk);
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
    for (int r = R - 1; r >= 0; r--) begin
      exp_q.push_back(ref_row(cur_mode, k_len, r));
    end
  endtask

  // all rows out and all credits paid back
  task automatic wait_drain(input string what);
    int n;
    n = 0;
    if (timed_out) begin
      return;
    end
    while ((exp_q.size() != 0 || returned_total != rows_total || !tile_ready)
           && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n >= wait_limit) begin
      $display("timeout: results of %s never fully drained", what);
      timed_out = 1'b1;
    end
  endtask

  task automatic start_test(input logic back_pressure);
    err_mark = errors;
    row_mark = rows_total;
    bp_on    = back_pressure;
  endtask

  task automatic finish_test(input string name);
    wait_drain(name);
    bp_on = 1'b0;
    $display("test %s done: %0d rows, %0d errors", name, rows_total - row_mark,
             errors - err_mark);
  endtask

  // random K, short random idle gaps between tiles
  task automatic run_random(input string name, input int n_tiles, input logic back_pressure);
    logic [31:0] v;
    start_test(back_pressure);
    for (int t = 0; t < n_tiles; t++) begin
      draw_bits(stim_lfsr, 2, v);
      repeat (v[1:0]) @(negedge clk);
      draw_bits(stim_lfsr, 6, v);
      drive_tile(int'(v[5:0]) + 1);
    end
    finish_test(name);
  endtask

  //////////////////////////////////////////////////
  // credit driver
  //////////////////////////////////////////////////

  // pays back one credit per received row, holds back at random under back-pressure
  always @(negedge clk) begin : credit_drive
    logic [31:0] v;
    if (reset) begin
      credit_return = 1'b0;
      issued_total  = 0;
      hold_cnt      = 0;
    end else if (hold_cnt > 0) begin
      credit_return = 1'b0;
      hold_cnt--;
    end else if (issued_total < rows_total) begin
      draw_bits(crd_lfsr, 2, v);
      if (bp_on && v[1:0] != 2'b11) begin
        draw_bits(crd_lfsr, 5, v);
        hold_cnt      = int'(v[4:0]);
        credit_return = 1'b0;
      end else begin
        credit_return = 1'b1;
        issued_total++;
      end
    end else begin
      credit_return = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////

  always @(posedge clk) begin : compare
    logic [RW-1:0] exp_row;
    if (reset) begin
      rows_total     = 0;
      returned_total = 0;
    end else begin
      // credit check uses returns seen before this edge
      if (out_valid) begin
        check_credit(rows_total - returned_total);
        if (exp_q.size() == 0) begin
          $display("ERR at %0t: row came out with no row expected", $time);
          errors++;
        end else begin
          exp_row = exp_q.pop_front();
          check_row(out_row, exp_row);
        end
        rows_total++;
      end
      if (credit_return) begin
        returned_total++;
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : main
    clk            = 1'b0;
    reset          = 1'b1;
    mode_init      = sa_data_pkg::mode_88;
    pix_in         = '0;
    wgt_in         = '0;
    in_valid       = 1'b0;
    in_last        = 1'b0;
    credit_return  = 1'b0;
    cur_mode       = sa_data_pkg::mode_88;
    stim_lfsr      = 32'hf453;
    crd_lfsr       = 32'hf453;
    errors         = 0;
    checks         = 0;
    rows_total     = 0;
    returned_total = 0;
    issued_total   = 0;
    hold_cnt       = 0;
    bp_on          = 1'b0;
    timed_out      = 1'b0;

    // idle state straight out of reset
    apply_reset(sa_data_pkg::mode_88);
    start_test(1'b0);
    @(negedge clk);
    check_ready(out_valid, 1'b0, "out_valid after reset");
    check_ready(tile_ready, 1'b1, "tile_ready after reset");
    finish_test("reset_state");

    // signed weights, borrow between lanes
    run_random("mode_88", 8, 1'b0);

    apply_reset(sa_data_pkg::mode_18);
    run_random("mode_18", 8, 1'b0);

    apply_reset(sa_data_pkg::mode_88);
    run_random("back_pressure", 8, 1'b1);

    // no gaps, long and short tiles mixed so stale sums would show
    start_test(1'b0);
    drive_tile(kmax);
    drive_tile(1);
    drive_tile(kmax);
    drive_tile(1);
    drive_tile(2);
    finish_test("back_to_back");

    if (timed_out) begin
      $display("run stopped early after a timeout");
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+test
design/sa_cfg_pkg.sv
design/sa_data_pkg.sv
design/operand_packer.sv
design/mac_cell.sv
design/mac_array.sv
design/sum_deskew.sv
design/result_unpacker.sv
design/packed_sa_top.sv
test/tb_packed_sa.sv

//--- Bender.yml
package:
  name: packed_sa

sources:
  - files:
      - design/sa_cfg_pkg.sv
      - design/sa_data_pkg.sv
      - design/operand_packer.sv
      - design/mac_cell.sv
      - design/mac_array.sv
      - design/sum_deskew.sv
      - design/result_unpacker.sv
      - design/packed_sa_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_packed_sa.sv
